// File: rtl/engine_pkg.sv
/*
 datapath definitions shared by all functional units
 data width, bus source and ALU opcode enums,
 data bus struct and the bus source selector
 */
package engine_pkg;

   localparam int DATA_W = 16;

   // bus sources, value is the word index on the data bus
   typedef enum logic [3:0] {
      SRC_ZERO  = 4'd0,
      SRC_ONE   = 4'd1,
      SRC_MEM0A = 4'd2,
      SRC_MEM0B = 4'd3,
      SRC_MEM1A = 4'd4,
      SRC_MEM1B = 4'd5,
      SRC_ALU0  = 4'd6,
      SRC_ALU1  = 4'd7,
      SRC_MUL0  = 4'd8
   } src_t;

   localparam int N_SRC = 9;

   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_SUB    = 3'd1,
      ALU_AND    = 3'd2,
      ALU_OR     = 3'd3,
      ALU_XOR    = 3'd4,
      ALU_MAX    = 3'd5,
      ALU_PASS_A = 3'd6
   } alu_op_t;

   // last member sits in the low bits, so word k is source k
   typedef struct packed {
      logic [DATA_W-1:0] mul0;
      logic [DATA_W-1:0] alu1;
      logic [DATA_W-1:0] alu0;
      logic [DATA_W-1:0] mem1b;
      logic [DATA_W-1:0] mem1a;
      logic [DATA_W-1:0] mem0b;
      logic [DATA_W-1:0] mem0a;
      logic [DATA_W-1:0] one;
      logic [DATA_W-1:0] zero;
   } data_bus_t;

   // operand pick from the bus, unused codes read as zero
   function automatic logic [DATA_W-1:0] bus_sel(data_bus_t bus, src_t src);
      logic [N_SRC-1:0][DATA_W-1:0] words;
      words = bus;
      if (int'(src) < N_SRC)
         return words[src];
      return '0;
   endfunction

endpackage

// File: rtl/conf_pkg.sv
/*
 configuration and host access definitions
 per-unit configuration structs, APB request and response,
 host memory access and the register map
 */
package conf_pkg;

   localparam int MEM_ADDR_W_MAX = 8;

   typedef struct packed {
      logic                      en;
      logic                      write;
      engine_pkg::src_t          src;
      logic [MEM_ADDR_W_MAX-1:0] start;
      logic [MEM_ADDR_W_MAX-1:0] incr;
      logic [9:0]                count;
      logic [3:0]                delay;
   } mem_port_conf_t;

   typedef struct packed {
      engine_pkg::alu_op_t op;
      engine_pkg::src_t    src_a;
      engine_pkg::src_t    src_b;
   } alu_conf_t;

   typedef struct packed {
      engine_pkg::src_t src_a;
      engine_pkg::src_t src_b;
   } mul_conf_t;

   // mem_port index: 0 mem0A, 1 mem0B, 2 mem1A, 3 mem1B
   typedef struct packed {
      mem_port_conf_t [3:0] mem_port;
      alu_conf_t [1:0]      alu;
      mul_conf_t            mul0;
   } engine_conf_t;

   typedef struct packed {
      logic [11:0] paddr;
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   typedef struct packed {
      logic                          valid;
      logic                          write;
      logic                          mem;
      logic [MEM_ADDR_W_MAX-1:0]     addr;
      logic [engine_pkg::DATA_W-1:0] data;
   } host_mem_t;

   typedef enum logic [2:0] {REG_CTRL, REG_STATUS, REG_CONF, REG_MEM, REG_NONE} reg_sel_t;

   localparam logic [11:0] CTRL_ADDR   = 12'h000;
   localparam logic [11:0] STATUS_ADDR = 12'h004;
   localparam logic [11:0] CONF_BASE   = 12'h040;
   localparam logic [11:0] CONF_END    = 12'h05C;
   localparam int          CONF_WORDS  = 8;
   localparam logic [11:0] MEM_BASE    = 12'h800;
   // memory index bit, word address right below it
   localparam int          MEM_SEL_BIT = 10;

endpackage

// File: rtl/conf_regs.sv
/*
 APB register block with configuration staging, the run command,
 status readback and the memory window with one wait state
 */
module conf_regs (
   input  logic                          rst,
   input  logic                          clk,
   input  conf_pkg::apb_req_t            apb_req,
   output conf_pkg::apb_rsp_t            apb_rsp,
   output conf_pkg::engine_conf_t        conf,
   output logic                          run,
   output conf_pkg::host_mem_t           host_mem,
   input  logic [engine_pkg::DATA_W-1:0] host_rdata,
   input  logic                          done
);
   import engine_pkg::*;
   import conf_pkg::*;

   typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_RESP} rd_state_t;

   rd_state_t                        state;
   logic [CONF_WORDS-1:0][31:0]      conf_words;
   logic [CONF_WORDS*32-1:0]         conf_flat;
   reg_sel_t                         sel;
   logic                             setup;
   logic                             access;
   logic [2:0]                       word_idx;

   assign setup    = apb_req.psel && !apb_req.penable;
   assign access   = apb_req.psel && apb_req.penable;
   assign word_idx = apb_req.paddr[4:2];

   // address decode
   always_comb begin
      sel = REG_NONE;
      if (apb_req.paddr >= MEM_BASE)
         sel = REG_MEM;
      else if (apb_req.paddr == CTRL_ADDR)
         sel = REG_CTRL;
      else if (apb_req.paddr == STATUS_ADDR)
         sel = REG_STATUS;
      else if (apb_req.paddr >= CONF_BASE && apb_req.paddr <= CONF_END &&
               apb_req.paddr[1:0] == 2'b00)
         sel = REG_CONF;
   end

   // memory window read sequence
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: if (setup && sel == REG_MEM && !apb_req.pwrite) state <= ST_WAIT;
            ST_WAIT: if (access) state <= ST_RESP;
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk)
         conf_words <= '0;
      else if (access && apb_req.pwrite && sel == REG_CONF)
         conf_words[word_idx] <= apb_req.pwdata;
   end

   // staged copy with the low word first
   assign conf_flat = conf_words;
   assign conf      = conf_flat[$bits(engine_conf_t)-1:0];
   assign run       = access && apb_req.pwrite && sel == REG_CTRL && apb_req.pwdata[0];

   always_comb begin
      host_mem.valid = access && sel == REG_MEM && (apb_req.pwrite || state == ST_WAIT);
      host_mem.write = apb_req.pwrite;
      host_mem.mem   = apb_req.paddr[MEM_SEL_BIT];
      host_mem.addr  = apb_req.paddr[MEM_SEL_BIT-1 -: MEM_ADDR_W_MAX];
      host_mem.data  = apb_req.pwdata[DATA_W-1:0];
   end

   always_comb begin
      apb_rsp.pready  = 1'b0;
      apb_rsp.pslverr = 1'b0;
      apb_rsp.prdata  = '0;
      if (access) begin
         apb_rsp.pready  = sel != REG_MEM || apb_req.pwrite || state == ST_RESP;
         apb_rsp.pslverr = sel == REG_NONE;
      end
      case (sel)
         REG_STATUS: apb_rsp.prdata = {31'b0, done};
         REG_CONF:   apb_rsp.prdata = conf_words[word_idx];
         REG_MEM:    apb_rsp.prdata = {{(32-DATA_W){1'b0}}, host_rdata};
         default:    apb_rsp.prdata = '0;
      endcase
   end

endmodule

// File: rtl/data_mem.sv
/*
 dual-port data memory
 one address generator per port, host access through port A
 */
module data_mem #(
   parameter int MEM_ADDR_W = 6
) (
   input  logic                          rst,
   input  logic                          clk,
   input  logic                          start,
   input  conf_pkg::mem_port_conf_t      port_a_conf,
   input  conf_pkg::mem_port_conf_t      port_b_conf,
   input  engine_pkg::data_bus_t         bus,
   output logic [engine_pkg::DATA_W-1:0] out_a,
   output logic [engine_pkg::DATA_W-1:0] out_b,
   output logic                          done_a,
   output logic                          done_b,
   input  conf_pkg::host_mem_t           host_mem,
   input  logic                          host_sel,
   output logic [engine_pkg::DATA_W-1:0] host_rdata
);
   import engine_pkg::*;
   import conf_pkg::*;

   logic [DATA_W-1:0]                ram [2**MEM_ADDR_W];
   mem_port_conf_t [1:0]             pconf;
   logic [1:0][MEM_ADDR_W-1:0]       gen_addr;
   logic [1:0][DATA_W-1:0]           gen_wdata;
   logic [1:0]                       gen_busy;
   logic [1:0]                       gen_we;
   logic [1:0]                       gen_rd;
   logic                             host_en;
   logic [MEM_ADDR_W-1:0]            addr_a;
   logic                             we_a;
   logic                             rd_a;
   logic [DATA_W-1:0]                wdata_a;
   logic [DATA_W-1:0]                rdata_a;
   logic [DATA_W-1:0]                rdata_b;

   assign pconf = {port_b_conf, port_a_conf};

   for (genvar p = 0; p < 2; p++) begin : g_port
      logic [MEM_ADDR_W-1:0] addr;
      logic [9:0]            iter;
      logic [3:0]            wait_cnt;
      logic                  busy;
      logic                  step;

      always_ff @(posedge rst or posedge clk) begin
         if (clk) begin
            addr     <= '0;
            iter     <= '0;
            wait_cnt <= '0;
            busy     <= 1'b0;
         end else if (start) begin
            addr     <= pconf[p].start[MEM_ADDR_W-1:0];
            iter     <= '0;
            // delay only applies to writers
            wait_cnt <= pconf[p].write ? pconf[p].delay : 4'd0;
            busy     <= pconf[p].en && pconf[p].count != '0;
         end else if (busy) begin
            if (wait_cnt != '0) begin
               wait_cnt <= wait_cnt - 4'd1;
            end else begin
               addr <= addr + pconf[p].incr[MEM_ADDR_W-1:0];
               iter <= iter + 10'd1;
               if (iter == pconf[p].count - 10'd1)
                  busy <= 1'b0;
            end
         end
      end

      assign step         = busy && wait_cnt == '0;
      assign gen_addr[p]  = addr;
      assign gen_busy[p]  = busy;
      assign gen_we[p]    = step && pconf[p].write;
      assign gen_rd[p]    = step && !pconf[p].write;
      assign gen_wdata[p] = bus_sel(bus, pconf[p].src);
   end

   // host only gets port A while both generators are idle
   assign host_en = host_mem.valid && host_sel && gen_busy == 2'b00;
   assign addr_a  = host_en ? host_mem.addr[MEM_ADDR_W-1:0] : gen_addr[0];
   assign we_a    = host_en ? host_mem.write : gen_we[0];
   assign rd_a    = host_en ? !host_mem.write : gen_rd[0];
   assign wdata_a = host_en ? host_mem.data : gen_wdata[0];

   always_ff @(posedge rst) begin
      if (we_a)
         ram[addr_a] <= wdata_a;
      if (gen_we[1])
         ram[gen_addr[1]] <= gen_wdata[1];
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         rdata_a <= '0;
         rdata_b <= '0;
      end else begin
         if (rd_a)
            rdata_a <= ram[addr_a];
         if (gen_rd[1])
            rdata_b <= ram[gen_addr[1]];
      end
   end

   assign out_a      = rdata_a;
   assign out_b      = rdata_b;
   assign host_rdata = rdata_a;
   assign done_a     = !gen_busy[0];
   assign done_b     = !gen_busy[1];

endmodule

// File: rtl/fu_alu.sv
/*
 registered two-operand ALU
 operands picked from the data bus by source code
 */
module fu_alu (
   input  logic                          rst,
   input  logic                          clk,
   input  logic                          clear,
   input  conf_pkg::alu_conf_t           conf,
   input  engine_pkg::data_bus_t         bus,
   output logic [engine_pkg::DATA_W-1:0] result
);
   import engine_pkg::*;

   logic [DATA_W-1:0] op_a;
   logic [DATA_W-1:0] op_b;
   logic [DATA_W-1:0] alu_next;

   assign op_a = bus_sel(bus, conf.src_a);
   assign op_b = bus_sel(bus, conf.src_b);

   always_comb begin
      case (conf.op)
         ALU_ADD:    alu_next = op_a + op_b;
         ALU_SUB:    alu_next = op_a - op_b;
         ALU_AND:    alu_next = op_a & op_b;
         ALU_OR:     alu_next = op_a | op_b;
         ALU_XOR:    alu_next = op_a ^ op_b;
         // unsigned compare
         ALU_MAX:    alu_next = (op_a > op_b) ? op_a : op_b;
         ALU_PASS_A: alu_next = op_a;
         default:    alu_next = '0;
      endcase
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk)
         result <= '0;
      else if (clear)
         result <= '0;
      else
         result <= alu_next;
   end

endmodule

// File: rtl/fu_mul.sv
/*
 registered multiplier that keeps the low half of the product
 */
module fu_mul (
   input  logic                          rst,
   input  logic                          clk,
   input  logic                          clear,
   input  conf_pkg::mul_conf_t           conf,
   input  engine_pkg::data_bus_t         bus,
   output logic [engine_pkg::DATA_W-1:0] result
);
   import engine_pkg::*;

   logic [DATA_W-1:0] op_a;
   logic [DATA_W-1:0] op_b;
   logic [DATA_W-1:0] product;

   assign op_a    = bus_sel(bus, conf.src_a);
   assign op_b    = bus_sel(bus, conf.src_b);
   assign product = op_a * op_b;

   always_ff @(posedge rst or posedge clk) begin
      if (clk)
         result <= '0;
      else if (clear)
         result <= '0;
      else
         result <= product;
   end

endmodule

// File: rtl/data_engine.sv
/*
 data engine: configuration shadow, run to start pulse,
 shared data bus, memories, ALUs and multiplier,
 host access steering and the done flag
 */
module data_engine #(
   parameter int MEM_ADDR_W = 6
) (
   input  logic                          rst,
   input  logic                          clk,
   input  conf_pkg::engine_conf_t        conf,
   input  logic                          run,
   input  conf_pkg::host_mem_t           host_mem,
   output logic [engine_pkg::DATA_W-1:0] host_rdata,
   output logic                          done
);
   import engine_pkg::*;
   import conf_pkg::*;

   engine_conf_t      shadow;
   logic              start;
   logic              host_mem_q;
   data_bus_t         bus;
   logic [3:0]        port_done;
   logic [DATA_W-1:0] mem0a;
   logic [DATA_W-1:0] mem0b;
   logic [DATA_W-1:0] mem1a;
   logic [DATA_W-1:0] mem1b;
   logic [DATA_W-1:0] alu0;
   logic [DATA_W-1:0] alu1;
   logic [DATA_W-1:0] mul0;
   logic [DATA_W-1:0] mem0_rdata;
   logic [DATA_W-1:0] mem1_rdata;

   // units run from the shadow, so staged writes wait for the next run
   always_ff @(posedge rst or posedge clk) begin
      if (clk)
         shadow <= '0;
      else if (run)
         shadow <= conf;
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         start      <= 1'b0;
         host_mem_q <= 1'b0;
      end else begin
         start <= run;
         // remember which memory answers the host read
         if (host_mem.valid)
            host_mem_q <= host_mem.mem;
      end
   end

   assign bus = '{
      zero:  '0,
      one:   DATA_W'(1),
      mem0a: mem0a,
      mem0b: mem0b,
      mem1a: mem1a,
      mem1b: mem1b,
      alu0:  alu0,
      alu1:  alu1,
      mul0:  mul0
   };

   data_mem #(.MEM_ADDR_W(MEM_ADDR_W)) u_mem0 (
      .rst         (rst),
      .clk         (clk),
      .start       (start),
      .port_a_conf (shadow.mem_port[0]),
      .port_b_conf (shadow.mem_port[1]),
      .bus         (bus),
      .out_a       (mem0a),
      .out_b       (mem0b),
      .done_a      (port_done[0]),
      .done_b      (port_done[1]),
      .host_mem    (host_mem),
      .host_sel    (!host_mem.mem),
      .host_rdata  (mem0_rdata)
   );

   data_mem #(.MEM_ADDR_W(MEM_ADDR_W)) u_mem1 (
      .rst         (rst),
      .clk         (clk),
      .start       (start),
      .port_a_conf (shadow.mem_port[2]),
      .port_b_conf (shadow.mem_port[3]),
      .bus         (bus),
      .out_a       (mem1a),
      .out_b       (mem1b),
      .done_a      (port_done[2]),
      .done_b      (port_done[3]),
      .host_mem    (host_mem),
      .host_sel    (host_mem.mem),
      .host_rdata  (mem1_rdata)
   );

   fu_alu u_alu0 (
      .rst    (rst),
      .clk    (clk),
      .clear  (start),
      .conf   (shadow.alu[0]),
      .bus    (bus),
      .result (alu0)
   );

   fu_alu u_alu1 (
      .rst    (rst),
      .clk    (clk),
      .clear  (start),
      .conf   (shadow.alu[1]),
      .bus    (bus),
      .result (alu1)
   );

   fu_mul u_mul0 (
      .rst    (rst),
      .clk    (clk),
      .clear  (start),
      .conf   (shadow.mul0),
      .bus    (bus),
      .result (mul0)
   );

   assign host_rdata = host_mem_q ? mem1_rdata : mem0_rdata;

   // low during the start cycle, before the generators report busy
   assign done = &port_done && !start;

endmodule

// File: rtl/engine_top.sv
/*
 top level: APB register block and data engine
 */
module engine_top #(
   parameter int MEM_ADDR_W = 6
) (
   input  logic               rst,
   input  logic               clk,
   input  conf_pkg::apb_req_t apb_req,
   output conf_pkg::apb_rsp_t apb_rsp
);
   import engine_pkg::*;
   import conf_pkg::*;

   engine_conf_t      conf;
   logic              run;
   host_mem_t         host_mem;
   logic [DATA_W-1:0] host_rdata;
   logic              done;

   conf_regs u_conf_regs (
      .rst        (rst),
      .clk        (clk),
      .apb_req    (apb_req),
      .apb_rsp    (apb_rsp),
      .conf       (conf),
      .run        (run),
      .host_mem   (host_mem),
      .host_rdata (host_rdata),
      .done       (done)
   );

   data_engine #(.MEM_ADDR_W(MEM_ADDR_W)) u_engine (
      .rst        (rst),
      .clk        (clk),
      .conf       (conf),
      .run        (run),
      .host_mem   (host_mem),
      .host_rdata (host_rdata),
      .done       (done)
   );

endmodule

// File: tests/tb_engine.sv
/*
 directed testbench for engine_top
 clock, reset, APB tasks, compare tasks, tests and watchdog
 */
module tb_engine;
   import engine_pkg::*;
   import conf_pkg::*;

   localparam int CLK_HALF     = 10;
   localparam int CLK_PERIOD   = 2 * CLK_HALF;
   localparam int MEM_ADDR_W   = 6;
   localparam int WINDOW_WORDS = 32;
   localparam int PREADY_LIMIT = 4;
   localparam int POLL_LIMIT   = 40;
   // window test, seven engine runs, reset test
   localparam int TEST_CYCLES  = 2 * WINDOW_WORDS * 7 + 7 * 160 + 40;
   localparam int WATCHDOG     = 2 * TEST_CYCLES * CLK_PERIOD;

   // rst carries the clock, clk the active high reset
   logic     rst;
   logic     clk;
   apb_req_t apb_req;
   apb_rsp_t apb_rsp;

   logic [DATA_W-1:0] mem_model [2][WINDOW_WORDS];
   int                test_errors;
   int                tests_passed;
   int                tests_failed;
   int                last_waits;

   engine_top #(.MEM_ADDR_W(MEM_ADDR_W)) uut (
      .rst     (rst),
      .clk     (clk),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp)
   );

   always #(CLK_HALF) rst = ~rst;

   task automatic check_word(input string what, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_status(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR at %0t: %s got %b expected %b", $time, what, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_err(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR at %0t: %s pslverr %b expected %b", $time, what, got, exp);
         test_errors++;
      end
   endtask

   // setup on one falling edge, access on the next, outputs sampled at rising edges
   task automatic apb_transfer(input logic [11:0] addr, input logic write,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
      int n;
      @(negedge rst);
      apb_req.paddr   = addr;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.pwdata  = wdata;
      @(negedge rst);
      apb_req.penable = 1'b1;
      n = 0;
      @(posedge rst);
      while (!apb_rsp.pready && n < PREADY_LIMIT) begin
         n++;
         @(posedge rst);
      end
      if (!apb_rsp.pready) begin
         $display("APB access to %h never got pready after %0d wait cycles", addr, n);
         test_errors++;
      end
      rdata      = apb_rsp.prdata;
      err        = apb_rsp.pslverr;
      last_waits = n;
      @(negedge rst);
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
   endtask

   task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
      logic [31:0] rd;
      logic        err;
      apb_transfer(addr, 1'b1, data, rd, err);
      check_err($sformatf("write to %h", addr), err, 1'b0);
   endtask

   task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
      logic err;
      apb_transfer(addr, 1'b0, 32'h0, data, err);
      check_err($sformatf("read from %h", addr), err, 1'b0);
   endtask

   function automatic logic [11:0] mem_addr(input int mem, input int word);
      return MEM_BASE | 12'(mem << MEM_SEL_BIT) | 12'(word << 2);
   endfunction

   function automatic mem_port_conf_t port_conf(input logic write, input src_t src,
                                                input logic [7:0] start,
                                                input logic [7:0] incr,
                                                input logic [9:0] count,
                                                input logic [3:0] delay);
      mem_port_conf_t p;
      p.en    = 1'b1;
      p.write = write;
      p.src   = src;
      p.start = start;
      p.incr  = incr;
      p.count = count;
      p.delay = delay;
      return p;
   endfunction

   // mem0 port A streams 0..15 through alu0 into mem1 port B
   function automatic engine_conf_t pipeline_conf(input alu_op_t op);
      engine_conf_t c;
      c = '0;
      c.mem_port[0] = port_conf(1'b0, SRC_ZERO, 8'd0, 8'd1, 10'd16, 4'd0);
      c.mem_port[3] = port_conf(1'b1, SRC_ALU0, 8'd0, 8'd1, 10'd16, 4'd2);
      c.alu[0]      = '{op: op, src_a: SRC_MEM0A, src_b: SRC_ONE};
      return c;
   endfunction

   function automatic logic [DATA_W-1:0] predict_alu(input alu_op_t op,
                                                     input logic [DATA_W-1:0] a,
                                                     input logic [DATA_W-1:0] b);
      case (op)
         ALU_ADD: return a + b;
         ALU_SUB: return a - b;
         ALU_XOR: return a ^ b;
         ALU_MAX: return (a > b) ? a : b;
         default: return a;
      endcase
   endfunction

   // configuration words go out low word first
   task automatic load_conf(input engine_conf_t c);
      logic [CONF_WORDS*32-1:0] bits;
      bits = '0;
      bits[$bits(engine_conf_t)-1:0] = c;
      for (int k = 0; k < CONF_WORDS; k++)
         apb_write(CONF_BASE + 12'(k * 4), bits[k*32 +: 32]);
   endtask

   task automatic wait_done();
      logic [31:0] st;
      int          polls;
      polls = 0;
      apb_read(STATUS_ADDR, st);
      while (!st[0] && polls < POLL_LIMIT) begin
         polls++;
         apb_read(STATUS_ADDR, st);
      end
      if (!st[0]) begin
         $display("engine did not report done after %0d status polls", polls);
         test_errors++;
      end
   endtask

   task automatic run_engine();
      apb_write(CTRL_ADDR, 32'h1);
      wait_done();
   endtask

   task automatic check_mem(input int mem, input int word, input logic [DATA_W-1:0] exp,
                            input string what);
      logic [31:0] rd;
      apb_read(mem_addr(mem, word), rd);
      check_word($sformatf("%s mem%0d[%0d]", what, mem, word), rd[DATA_W-1:0], exp);
   endtask

   task automatic report_test(input string name);
      if (test_errors == 0) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   task automatic test_mem_window();
      logic [31:0] r;
      for (int m = 0; m < 2; m++) begin
         for (int k = 0; k < WINDOW_WORDS; k++) begin
            r = $urandom;
            mem_model[m][k] = r[DATA_W-1:0];
            apb_write(mem_addr(m, k), {16'h0, r[DATA_W-1:0]});
         end
      end
      for (int m = 0; m < 2; m++) begin
         for (int k = 0; k < WINDOW_WORDS; k++) begin
            check_mem(m, k, mem_model[m][k], "window readback");
            check_status("one wait state on memory read", last_waits == 1, 1'b1);
         end
      end
      report_test("memory window");
   endtask

   task automatic test_reset_state();
      logic [31:0] rd;
      logic        err;
      @(posedge rst);
      check_status("pready outside an access", apb_rsp.pready, 1'b0);
      apb_read(STATUS_ADDR, rd);
      check_status("status done after reset", rd[0], 1'b1);
      apb_transfer(12'h100, 1'b0, 32'h0, rd, err);
      check_err("read from unmapped 100", err, 1'b1);
      apb_transfer(12'h008, 1'b1, 32'h5, rd, err);
      check_err("write to unmapped 008", err, 1'b1);
      report_test("reset state and errors");
   endtask

   task automatic test_alu(input alu_op_t op);
      load_conf(pipeline_conf(op));
      run_engine();
      for (int k = 0; k < 16; k++)
         check_mem(1, k, predict_alu(op, mem_model[0][k], 16'd1), op.name());
      report_test($sformatf("alu pipeline %s", op.name()));
   endtask

   task automatic test_mul_stride();
      engine_conf_t        c;
      logic [2*DATA_W-1:0] prod;
      c = '0;
      c.mem_port[0] = port_conf(1'b0, SRC_ZERO, 8'd0, 8'd2, 10'd16, 4'd0);
      c.mem_port[1] = port_conf(1'b0, SRC_ZERO, 8'd0, 8'd1, 10'd16, 4'd0);
      c.mem_port[3] = port_conf(1'b1, SRC_MUL0, 8'd0, 8'd1, 10'd16, 4'd2);
      c.mul0        = '{src_a: SRC_MEM0A, src_b: SRC_MEM0B};
      load_conf(c);
      run_engine();
      for (int k = 0; k < 16; k++) begin
         prod = mem_model[0][2*k] * mem_model[0][k];
         check_mem(1, k, prod[DATA_W-1:0], "product");
      end
      report_test("multiplier with stride");
   endtask

   // add then subtract, so the two runs never agree on a word
   task automatic test_shadow();
      logic [31:0] st;
      load_conf(pipeline_conf(ALU_ADD));
      apb_write(CTRL_ADDR, 32'h1);
      apb_read(STATUS_ADDR, st);
      check_status("status busy during run", st[0], 1'b0);
      load_conf(pipeline_conf(ALU_SUB));
      wait_done();
      for (int k = 0; k < 16; k++)
         check_mem(1, k, mem_model[0][k] + 16'd1, "old config");
      run_engine();
      for (int k = 0; k < 16; k++)
         check_mem(1, k, mem_model[0][k] - 16'd1, "new config");
      report_test("shadow configuration");
   endtask

   initial begin
      void'($urandom(32'hc0a7));
      test_errors  = 0;
      tests_passed = 0;
      tests_failed = 0;
      last_waits   = 0;
      rst          = 1'b0;
      clk          = 1'b1;
      apb_req      = '0;
      repeat (8) @(negedge rst);
      clk = 1'b0;

      test_mem_window();
      test_reset_state();
      test_alu(ALU_ADD);
      test_alu(ALU_SUB);
      test_alu(ALU_XOR);
      test_alu(ALU_MAX);
      test_mul_stride();
      test_shadow();

      $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      #(WATCHDOG);
      $display("timeout: the tests did not finish within %0d time units", WATCHDOG);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// File: verilog.f
rtl/engine_pkg.sv
rtl/conf_pkg.sv
rtl/conf_regs.sv
rtl/data_mem.sv
rtl/fu_alu.sv
rtl/fu_mul.sv
rtl/data_engine.sv
rtl/engine_top.sv
tests/tb_engine.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_engine -f verilog.f -o tb_engine \
   && ./obj_dir/tb_engine | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
   && echo "simulation result: pass" \
   || { echo "simulation result: fail"; exit 1; }
